// ==== Bender.yml ====
package:
  name: tile_gen

sources:
  - files:
      - rtl/tile_pkg.sv
      - rtl/tile_regs_axil.sv
      - rtl/tile_fetch.sv
      - rtl/tile_layer.sv
      - rtl/tile_out.sv
      - rtl/tile_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_tile_top.sv

// ==== list.f ====
+incdir+testbench
rtl/tile_pkg.sv
rtl/tile_regs_axil.sv
rtl/tile_fetch.sv
rtl/tile_layer.sv
rtl/tile_out.sv
rtl/tile_top.sv
testbench/tb_tile_top.sv

// ==== rtl/tile_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_fetch import tile_pkg::*; #(
	parameter int NUM_LAYERS = 2
) (
	input wire CLK_2H,
	input wire rst_n,
	input wire run,
	// One tile word per layer
	input wire tile_valid,
	input tile_t tile_in [NUM_LAYERS],
	output logic tile_ready,
	// Captured words shared by the chain
	output tile_t tiles [NUM_LAYERS],
	// Head of the chain
	output pix_t seed,
	output underrun_t underrun
);

	logic [1:0] phase_q;
	logic group_start;
	logic in_group;
	logic seed_load_q;
	logic seed_valid_q;

	// Group starts only on phase 0 with run set
	assign group_start = run && (phase_q == 2'd0);
	// A started group always runs its four pixels
	assign in_group = group_start || (phase_q != 2'd0);
	assign tile_ready = group_start;

	//////////////////////////////////////////////////////////////////////
	// Phase counter, seed strobes and underrun count
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_2H) begin
		if (!rst_n) begin
			phase_q <= 2'd0;
			seed_load_q <= 1'b0;
			seed_valid_q <= 1'b0;
			underrun <= '0;
		end else begin
			if (in_group) phase_q <= phase_q + 2'd1;
			// Load marks pixel 0 of the group
			seed_load_q <= group_start;
			seed_valid_q <= in_group;
			// Count a missing tile word and saturate at all ones
			if (group_start && !tile_valid && underrun != '1) begin
				underrun <= underrun + underrun_t'(1);
			end
		end
	end

	// Transparent fill replaces the tiles on underrun
	always_ff @(posedge CLK_2H) begin
		if (group_start) begin
			for (int k = 0; k < NUM_LAYERS; k++) begin
				tiles[k] <= tile_valid ? tile_in[k] : TRANSPARENT_TILE;
			end
		end
	end

	// Seed is a transparent pixel that loses every merge
	assign seed = '{
		load: seed_load_q,
		valid: seed_valid_q,
		pri: '0,
		attr: '0,
		code: TRANSPARENT_CODE
	};

	// Groups are four cycles apart
	a_ready_pulse: assert property (@(posedge CLK_2H) disable iff (!rst_n)
		tile_ready |=> !tile_ready)
		else $error("tile_ready high on two cycles in a row");

endmodule

`default_nettype wire

// ==== rtl/tile_layer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_layer import tile_pkg::*; #(
	parameter int LAYER_INDEX = 0
) (
	input wire CLK_2H,
	input wire rst_n,
	input wire flip,
	input layer_cfg_t cfg,
	// Shared tile word, stable through the group
	input tile_t tile,
	input pix_t pix_in,
	output pix_t pix_out
);

	// Shift state for the rest of the group
	attr_t attr_q;
	pattern_t pat_q;

	attr_t cur_attr;
	pattern_t cur_pat;
	pattern_t nxt_pat;
	code_t code;
	logic take;

	// Registered chain pixel
	logic load_q;
	logic valid_q;
	pri_t out_pri;
	attr_t out_attr;
	code_t out_code;

	//////////////////////////////////////////////////////////////////////
	// Pixel select and merge
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// On load the first pixel comes straight from the tile word
		cur_attr = pix_in.load ? tile.attr : attr_q;
		cur_pat = pix_in.load ? tile.pattern : pat_q;
		code = '0;
		nxt_pat = '0;
		for (int p = 0; p < 3; p++) begin
			// Flip reads bit 0 and shifts right, else bit 3 and left
			code[p] = flip ? cur_pat[4 * p] : cur_pat[4 * p + 3];
			nxt_pat[4 * p +: 4] = flip ? {1'b0, cur_pat[4 * p + 1 +: 3]}
				: {cur_pat[4 * p +: 3], 1'b0};
		end
		// Strictly higher priority wins, ties stay with the lower layer
		take = cfg.en && (code != TRANSPARENT_CODE) && (cfg.pri > pix_in.pri);
	end

	// Shift registers
	always_ff @(posedge CLK_2H) begin
		attr_q <= cur_attr;
		pat_q <= nxt_pat;
	end

	// Strobes along the chain
	always_ff @(posedge CLK_2H) begin
		if (!rst_n) begin
			load_q <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			load_q <= pix_in.load;
			valid_q <= pix_in.valid;
		end
	end

	// Winner payload
	always_ff @(posedge CLK_2H) begin
		if (take) begin
			out_pri <= cfg.pri;
			out_attr <= cur_attr;
			out_code <= code;
		end else begin
			out_pri <= pix_in.pri;
			out_attr <= pix_in.attr;
			out_code <= pix_in.code;
		end
	end

	assign pix_out = '{
		load: load_q,
		valid: valid_q,
		pri: out_pri,
		attr: out_attr,
		code: out_code
	};

	// Load every four cycles until the stream stops
	a_load_period: assert property (@(posedge CLK_2H) disable iff (!rst_n)
		pix_in.load |=> (!pix_in.load) [*3] ##1 (pix_in.load || !pix_in.valid))
		else $error("layer %0d: load strobe out of step", LAYER_INDEX);

endmodule

`default_nettype wire

// ==== rtl/tile_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_out import tile_pkg::*; (
	input wire CLK_2H,
	input wire rst_n,
	input palidx_t backdrop,
	// Pixel from the last layer
	input pix_t pix_in,
	output logic pix_valid,
	output palidx_t pix_index
);

	palidx_t index_d;

	//////////////////////////////////////////////////////////////////////
	// Palette index
	//////////////////////////////////////////////////////////////////////

	// Backdrop when every layer is transparent
	always_comb begin
		if (pix_in.code == TRANSPARENT_CODE) begin
			index_d = backdrop;
		end else begin
			index_d = {pix_in.attr, pix_in.code};
		end
	end

	// Valid flag
	always_ff @(posedge CLK_2H) begin
		if (!rst_n) begin
			pix_valid <= 1'b0;
		end else begin
			pix_valid <= pix_in.valid;
		end
	end

	// Index register
	always_ff @(posedge CLK_2H) begin
		pix_index <= index_d;
	end

endmodule

`default_nettype wire

// ==== rtl/tile_pkg.sv ====
`default_nettype none

package tile_pkg;

	//////////////////////////////////////////////////////////////////////
	// Pixel and tile types
	//////////////////////////////////////////////////////////////////////

	// Layer priority, zero never wins a merge
	typedef logic [2:0] pri_t;
	// Pixel code, one bit per plane
	typedef logic [2:0] code_t;
	typedef logic [7:0] attr_t;
	// Plane 0 in the low nibble, plane 2 in the high nibble
	typedef logic [11:0] pattern_t;
	// Attribute and code side by side
	typedef logic [10:0] palidx_t;
	typedef logic [15:0] underrun_t;

	localparam code_t TRANSPARENT_CODE = 3'd7;

	typedef struct packed {
		attr_t attr;
		pattern_t pattern;
	} tile_t;

	// All planes set, every pixel comes out transparent
	localparam tile_t TRANSPARENT_TILE = '{attr: '0, pattern: '1};

	// Chain pixel, load marks pixel 0 of a group
	typedef struct packed {
		logic load;
		logic valid;
		pri_t pri;
		attr_t attr;
		code_t code;
	} pix_t;

	// Enable in bit 3, priority in bits 2..0
	typedef struct packed {
		logic en;
		pri_t pri;
	} layer_cfg_t;

	//////////////////////////////////////////////////////////////////////
	// AXI4-Lite register map
	//////////////////////////////////////////////////////////////////////

	typedef logic [7:0] axil_addr_t;
	typedef logic [31:0] axil_data_t;
	typedef logic [3:0] axil_strb_t;
	typedef logic [1:0] axil_resp_t;

	localparam axil_resp_t RESP_OKAY = 2'b00;
	localparam axil_resp_t RESP_SLVERR = 2'b10;

	localparam axil_addr_t REG_CTRL = 8'h00;
	localparam axil_addr_t REG_BACKDROP = 8'h04;
	localparam axil_addr_t REG_UNDERRUN = 8'h08;
	// Layer k at base plus 4k
	localparam axil_addr_t REG_LAYER_BASE = 8'h10;

endpackage

`default_nettype wire

// ==== rtl/tile_regs_axil.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_regs_axil import tile_pkg::*; #(
	parameter int NUM_LAYERS = 2
) (
	input wire CLK_2H,
	input wire rst_n,
	// Write address and data
	input axil_addr_t awaddr,
	input wire awvalid,
	output logic awready,
	input axil_data_t wdata,
	input axil_strb_t wstrb,
	input wire wvalid,
	output logic wready,
	// Write response
	output axil_resp_t bresp,
	output logic bvalid,
	input wire bready,
	// Read
	input axil_addr_t araddr,
	input wire arvalid,
	output logic arready,
	output axil_data_t rdata,
	output axil_resp_t rresp,
	output logic rvalid,
	input wire rready,
	// Control towards the pixel path
	output logic run,
	output logic flip,
	output palidx_t backdrop,
	output layer_cfg_t layer_cfg [NUM_LAYERS],
	input underrun_t underrun
);

	typedef enum logic [1:0] {W_IDLE, W_ACK, W_RESP} wr_state_e;
	typedef enum logic [1:0] {R_IDLE, R_ACK, R_DATA} rd_state_e;

	wr_state_e wr_state;
	rd_state_e rd_state;
	logic [NUM_LAYERS-1:0] wr_layer;
	logic wr_ok;
	logic rd_ok;
	axil_data_t rd_word;

	// Readies pulse in the ACK state, valids held in the response states
	assign awready = (wr_state == W_ACK);
	assign wready = (wr_state == W_ACK);
	assign bvalid = (wr_state == W_RESP);
	assign arready = (rd_state == R_ACK);
	assign rvalid = (rd_state == R_DATA);

	// Write decode, underrun is read only
	always_comb begin
		wr_layer = '0;
		for (int k = 0; k < NUM_LAYERS; k++) begin
			wr_layer[k] = (awaddr == REG_LAYER_BASE + axil_addr_t'(4 * k));
		end
		wr_ok = (awaddr == REG_CTRL) || (awaddr == REG_BACKDROP) || (|wr_layer);
	end

	// Read mux
	always_comb begin
		rd_word = '0;
		rd_ok = 1'b1;
		case (araddr)
			REG_CTRL: rd_word = {30'd0, flip, run};
			REG_BACKDROP: rd_word = {21'd0, backdrop};
			REG_UNDERRUN: rd_word = {16'd0, underrun};
			default: begin
				rd_ok = 1'b0;
				for (int k = 0; k < NUM_LAYERS; k++) begin
					if (araddr == REG_LAYER_BASE + axil_addr_t'(4 * k)) begin
						rd_word = {28'd0, layer_cfg[k]};
						rd_ok = 1'b1;
					end
				end
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Write channel
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_2H) begin
		if (!rst_n) begin
			wr_state <= W_IDLE;
			bresp <= RESP_OKAY;
			run <= 1'b0;
			flip <= 1'b0;
			backdrop <= '0;
			for (int k = 0; k < NUM_LAYERS; k++) begin
				layer_cfg[k] <= '0;
			end
		end else begin
			case (wr_state)
				// Wait for address and data together
				W_IDLE: if (awvalid && wvalid) wr_state <= W_ACK;
				W_ACK: begin
					wr_state <= W_RESP;
					bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
					if (awaddr == REG_CTRL && wstrb[0]) begin
						run <= wdata[0];
						flip <= wdata[1];
					end
					if (awaddr == REG_BACKDROP) begin
						if (wstrb[0]) backdrop[7:0] <= wdata[7:0];
						if (wstrb[1]) backdrop[10:8] <= wdata[10:8];
					end
					for (int k = 0; k < NUM_LAYERS; k++) begin
						if (wr_layer[k] && wstrb[0]) layer_cfg[k] <= layer_cfg_t'(wdata[3:0]);
					end
				end
				W_RESP: if (bready) wr_state <= W_IDLE;
				default: wr_state <= W_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read channel
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_2H) begin
		if (!rst_n) begin
			rd_state <= R_IDLE;
		end else begin
			case (rd_state)
				R_IDLE: if (arvalid) rd_state <= R_ACK;
				R_ACK: rd_state <= R_DATA;
				R_DATA: if (rready) rd_state <= R_IDLE;
				default: rd_state <= R_IDLE;
			endcase
		end
	end

	// Read data captured with the address handshake
	always_ff @(posedge CLK_2H) begin
		if (rd_state == R_ACK) begin
			rdata <= rd_word;
			rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// Response held until the master takes it
	a_bvalid_hold: assert property (@(posedge CLK_2H) disable iff (!rst_n)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	a_rdata_stable: assert property (@(posedge CLK_2H) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else $error("read data changed while rvalid held");

endmodule

`default_nettype wire

// ==== rtl/tile_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_top import tile_pkg::*; #(
	parameter int NUM_LAYERS = 2
) (
	input wire CLK_2H,
	input wire rst_n,
	// AXI4-Lite slave
	input axil_addr_t awaddr,
	input wire awvalid,
	output logic awready,
	input axil_data_t wdata,
	input axil_strb_t wstrb,
	input wire wvalid,
	output logic wready,
	output axil_resp_t bresp,
	output logic bvalid,
	input wire bready,
	input axil_addr_t araddr,
	input wire arvalid,
	output logic arready,
	output axil_data_t rdata,
	output axil_resp_t rresp,
	output logic rvalid,
	input wire rready,
	// Tile words in
	input wire tile_valid,
	input tile_t tile_in [NUM_LAYERS],
	output logic tile_ready,
	// Video out
	output logic pix_valid,
	output palidx_t pix_index
);

	logic run;
	logic flip;
	palidx_t backdrop;
	layer_cfg_t layer_cfg [NUM_LAYERS];
	underrun_t underrun;
	tile_t tiles [NUM_LAYERS];
	// Stage 0 is the seed, stage NUM_LAYERS feeds the output
	pix_t chain [NUM_LAYERS+1];

	// Tile words hold for one group only
	if (NUM_LAYERS < 1 || NUM_LAYERS > 4) begin : g_bad_layers
		$error("NUM_LAYERS must be 1 to 4");
	end

	//////////////////////////////////////////////////////////////////////
	// Registers and fetch
	//////////////////////////////////////////////////////////////////////

	tile_regs_axil #(.NUM_LAYERS(NUM_LAYERS)) i_regs (
		.CLK_2H(CLK_2H), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.run(run), .flip(flip), .backdrop(backdrop),
		.layer_cfg(layer_cfg), .underrun(underrun)
	);

	tile_fetch #(.NUM_LAYERS(NUM_LAYERS)) i_fetch (
		.CLK_2H(CLK_2H), .rst_n(rst_n), .run(run),
		.tile_valid(tile_valid), .tile_in(tile_in), .tile_ready(tile_ready),
		.tiles(tiles), .seed(chain[0]), .underrun(underrun)
	);

	// Layer chain, one cycle per layer
	for (genvar k = 0; k < NUM_LAYERS; k++) begin : g_layer
		tile_layer #(.LAYER_INDEX(k)) i_layer (
			.CLK_2H(CLK_2H), .rst_n(rst_n), .flip(flip),
			.cfg(layer_cfg[k]), .tile(tiles[k]),
			.pix_in(chain[k]), .pix_out(chain[k+1])
		);
	end

	tile_out i_out (
		.CLK_2H(CLK_2H), .rst_n(rst_n), .backdrop(backdrop),
		.pix_in(chain[NUM_LAYERS]),
		.pix_valid(pix_valid), .pix_index(pix_index)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_tile_tasks.svh ====
//////////////////////////////////////////////////////////////////////
// Random numbers
//////////////////////////////////////////////////////////////////////

// Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] bits;
	logic fb;
	bits = '0;
	for (int i = 0; i < n; i++) begin
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		bits = {bits[30:0], fb};
	end
	return bits;
endfunction

//////////////////////////////////////////////////////////////////////
// AXI4-Lite master
//////////////////////////////////////////////////////////////////////

// Entered and left 1 ns after a rising edge
task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
	output axil_resp_t resp);
	int n;
	awaddr = addr;
	wdata = data;
	wstrb = 4'hf;
	awvalid = 1'b1;
	wvalid = 1'b1;
	bready = 1'b0;
	for (n = 0; !(awready && wready); n++) begin
		if (n == AXI_TIMEOUT) stop_with_failure("timeout waiting for awready and wready");
		@(negedge CLK_2H);
	end
	// Handshake on the next edge
	@(posedge CLK_2H);
	#1;
	awvalid = 1'b0;
	wvalid = 1'b0;
	for (n = 0; !bvalid; n++) begin
		if (n == AXI_TIMEOUT) stop_with_failure("timeout waiting for bvalid");
		@(negedge CLK_2H);
	end
	// Response left waiting for one edge before it is taken
	@(posedge CLK_2H);
	#1;
	bready = 1'b1;
	resp = bresp;
	@(posedge CLK_2H);
	#1;
	bready = 1'b0;
endtask

task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
	output axil_resp_t resp);
	int n;
	araddr = addr;
	arvalid = 1'b1;
	rready = 1'b0;
	for (n = 0; !arready; n++) begin
		if (n == AXI_TIMEOUT) stop_with_failure("timeout waiting for arready");
		@(negedge CLK_2H);
	end
	@(posedge CLK_2H);
	#1;
	arvalid = 1'b0;
	for (n = 0; !rvalid; n++) begin
		if (n == AXI_TIMEOUT) stop_with_failure("timeout waiting for rvalid");
		@(negedge CLK_2H);
	end
	// Read data left waiting for one edge before it is taken
	@(posedge CLK_2H);
	#1;
	rready = 1'b1;
	data = rdata;
	resp = rresp;
	@(posedge CLK_2H);
	#1;
	rready = 1'b0;
endtask

//////////////////////////////////////////////////////////////////////
// Waits
//////////////////////////////////////////////////////////////////////

task automatic wait_for_groups(input int n);
	int first;
	int cycles;
	first = groups_seen;
	for (cycles = 0; groups_seen < first + n; cycles++) begin
		if (cycles == 4 * n + 40) stop_with_failure("timeout waiting for tile groups");
		@(posedge CLK_2H);
		#1;
	end
endtask

// Every expected pixel out and the stream stopped
task automatic wait_for_drain();
	int cycles;
	for (cycles = 0; exp_q.size() != 0 || pix_valid; cycles++) begin
		if (cycles == 60) stop_with_failure("timeout waiting for the pixel stream to drain");
		@(posedge CLK_2H);
		#1;
	end
endtask

// ==== testbench/tb_tile_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tile_top import tile_pkg::*; ();

	localparam int NUM_LAYERS = 2;
	localparam int AXI_TIMEOUT = 50;

	logic CLK_2H = 1'b0;
	logic rst_n;
	axil_addr_t awaddr, araddr;
	axil_data_t wdata, rdata;
	axil_strb_t wstrb;
	axil_resp_t bresp, rresp;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic tile_valid, tile_ready, pix_valid;
	tile_t tile_in [NUM_LAYERS];
	palidx_t pix_index;

	// Model state that changes only while the stream is idle
	logic flip_s;
	palidx_t backdrop_s;
	layer_cfg_t cfg_s [NUM_LAYERS];
	tile_t grp_tiles [NUM_LAYERS];
	palidx_t exp_q [$];
	palidx_t exp_idx;
	// Stimulus knobs
	logic all_clear;
	int starve_left;
	int groups_seen;
	logic [31:0] lfsr_state = 32'ha2d3_7f91;
	axil_data_t rd;
	axil_resp_t resp;

	always #2 CLK_2H = ~CLK_2H;

	tile_top #(.NUM_LAYERS(NUM_LAYERS)) i_tile_top (
		.CLK_2H(CLK_2H), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.tile_valid(tile_valid), .tile_in(tile_in), .tile_ready(tile_ready),
		.pix_valid(pix_valid), .pix_index(pix_index)
	);

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("TEST FAIL");
		$fatal(1, "stopped at the first failing check");
	endtask

	`include "tb_tile_tasks.svh"

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Pixel i of the captured group with the layers merged in chain order
	function automatic palidx_t expect_pixel(input int i);
		pri_t best_pri;
		attr_t best_attr;
		code_t best_code;
		code_t c;
		int b;
		best_pri = '0;
		best_attr = '0;
		best_code = TRANSPARENT_CODE;
		b = flip_s ? i : 3 - i;
		for (int k = 0; k < NUM_LAYERS; k++) begin
			c = {grp_tiles[k].pattern[8 + b], grp_tiles[k].pattern[4 + b],
				grp_tiles[k].pattern[b]};
			// Strictly greater, so ties keep the lower layer
			if (cfg_s[k].en && c != TRANSPARENT_CODE && cfg_s[k].pri > best_pri) begin
				best_pri = cfg_s[k].pri;
				best_attr = grp_tiles[k].attr;
				best_code = c;
			end
		end
		return (best_code == TRANSPARENT_CODE) ? backdrop_s : {best_attr, best_code};
	endfunction

	// Group start pushes four pixels and every output pixel pops one
	always @(negedge CLK_2H) begin
		if (rst_n) begin
			if (tile_ready) begin
				groups_seen++;
				for (int k = 0; k < NUM_LAYERS; k++) begin
					grp_tiles[k] = tile_valid ? tile_in[k]
						: tile_t'{attr: '0, pattern: 12'hfff};
				end
				for (int i = 0; i < 4; i++) exp_q.push_back(expect_pixel(i));
			end
			if (pix_valid) begin
				assert (exp_q.size() > 0)
					else stop_with_failure("a pixel came out with nothing expected");
				exp_idx = exp_q.pop_front();
				assert (pix_index === exp_idx)
					else stop_with_failure($sformatf("error pix_index: got %h expected %h",
						pix_index, exp_idx));
			end
		end
	end

	// New tile words at each group start
	always @(posedge CLK_2H) begin
		#1;
		if (rst_n && tile_ready) begin
			tile_valid = (starve_left == 0);
			if (starve_left > 0) starve_left--;
			for (int k = 0; k < NUM_LAYERS; k++) begin
				tile_in[k].attr = attr_t'(rand_bits(8));
				tile_in[k].pattern = pattern_t'(rand_bits(12));
				// Whole tile at code 7 now and then
				if (all_clear || rand_bits(2) == 0) tile_in[k].pattern = 12'hfff;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Register helpers
	//////////////////////////////////////////////////////////////////////

	task automatic reg_write(input axil_addr_t addr, input axil_data_t data);
		axil_resp_t r;
		axil_write(addr, data, r);
		assert (r == RESP_OKAY)
			else stop_with_failure($sformatf("error bresp at %h: got %h expected %h",
				addr, r, RESP_OKAY));
	endtask

	task automatic reg_expect(input axil_addr_t addr, input axil_data_t exp);
		axil_data_t d;
		axil_resp_t r;
		axil_read(addr, d, r);
		assert (r == RESP_OKAY)
			else stop_with_failure($sformatf("error rresp at %h: got %h expected %h",
				addr, r, RESP_OKAY));
		assert (d == exp)
			else stop_with_failure($sformatf("error rdata at %h: got %h expected %h",
				addr, d, exp));
	endtask

	task automatic load_config();
		reg_write(REG_BACKDROP, {21'd0, backdrop_s});
		for (int k = 0; k < NUM_LAYERS; k++) begin
			reg_write(REG_LAYER_BASE + axil_addr_t'(4 * k), {28'd0, cfg_s[k]});
		end
	endtask

	// Run n groups, then stop and let the chain empty
	task automatic play_round(input int n);
		reg_write(REG_CTRL, {30'd0, flip_s, 1'b1});
		wait_for_groups(n);
		reg_write(REG_CTRL, {30'd0, flip_s, 1'b0});
		wait_for_drain();
	endtask

	task automatic check_quiet(input string when);
		assert (!pix_valid && !tile_ready && !bvalid && !rvalid)
			else stop_with_failure($sformatf(
				"error %s: pix_valid %h tile_ready %h bvalid %h rvalid %h, all expected 0",
				when, pix_valid, tile_ready, bvalid, rvalid));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		rst_n = 1'b0;
		{awaddr, araddr, wdata, wstrb} = '0;
		{awvalid, wvalid, bready, arvalid, rready, tile_valid} = '0;
		for (int k = 0; k < NUM_LAYERS; k++) begin
			tile_in[k] = '0;
			cfg_s[k] = '0;
		end
		flip_s = 1'b0;
		backdrop_s = '0;
		all_clear = 1'b0;
		starve_left = 0;
		groups_seen = 0;
		repeat (5) begin
			@(posedge CLK_2H);
			#1;
			check_quiet("during reset");
		end
		rst_n = 1'b1;
		@(posedge CLK_2H);
		#1;
		check_quiet("after reset");

		// Readback and error responses
		reg_write(REG_CTRL, 32'h2);
		reg_expect(REG_CTRL, 32'h2);
		reg_write(REG_BACKDROP, 32'h5a3);
		reg_expect(REG_BACKDROP, 32'h5a3);
		reg_write(REG_LAYER_BASE, 32'hb);
		reg_write(REG_LAYER_BASE + 8'h4, 32'h6);
		reg_expect(REG_LAYER_BASE, 32'hb);
		reg_expect(REG_LAYER_BASE + 8'h4, 32'h6);
		reg_expect(REG_UNDERRUN, 32'h0);
		axil_write(8'h0c, 32'h1, resp);
		assert (resp == RESP_SLVERR)
			else stop_with_failure($sformatf("error bresp at 0c: got %h expected %h",
				resp, RESP_SLVERR));
		axil_write(REG_UNDERRUN, 32'h5, resp);
		assert (resp == RESP_SLVERR)
			else stop_with_failure($sformatf("error bresp at 08: got %h expected %h",
				resp, RESP_SLVERR));
		axil_read(8'h20, rd, resp);
		assert (resp == RESP_SLVERR)
			else stop_with_failure($sformatf("error rresp at 20: got %h expected %h",
				resp, RESP_SLVERR));

		// Tie at priority 3
		backdrop_s = 11'h123;
		cfg_s[0] = '{en: 1'b1, pri: 3'd3};
		cfg_s[1] = '{en: 1'b1, pri: 3'd3};
		load_config();
		play_round(12);
		// Layer 0 switched off
		cfg_s[0].en = 1'b0;
		cfg_s[1].pri = 3'd2;
		load_config();
		play_round(12);
		// Priority 0 on layer 1 never shows
		cfg_s[0] = '{en: 1'b1, pri: 3'd1};
		cfg_s[1] = '{en: 1'b1, pri: 3'd0};
		load_config();
		play_round(12);
		// Flipped groups with layer 1 on top
		flip_s = 1'b1;
		cfg_s[1].pri = 3'd6;
		load_config();
		play_round(12);
		// Every tile transparent
		all_clear = 1'b1;
		backdrop_s = 11'h6e5;
		load_config();
		play_round(8);
		all_clear = 1'b0;
		// Random configurations with flip on odd rounds
		for (int r = 0; r < 8; r++) begin
			for (int k = 0; k < NUM_LAYERS; k++) begin
				cfg_s[k].pri = pri_t'(rand_bits(3));
				cfg_s[k].en = (rand_bits(1) != 0);
			end
			backdrop_s = palidx_t'(rand_bits(11));
			flip_s = r[0];
			load_config();
			play_round(16);
		end

		// Three starved groups show the backdrop and are counted
		starve_left = 3;
		play_round(8);
		reg_expect(REG_UNDERRUN, 32'd3);
		check_quiet("at the end");

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire
